// File: verification/rv_exec_cases.txt
// inst     pc       wb rd data     rdir target     (all hex)
// Rows skipped by a jump or taken branch are never executed.
123450B7 00000100 1 01 12345000 0 00000000
FFB00113 00000104 1 02 FFFFFFFB 0 00000000
00710193 00000108 1 03 00000002 0 00000000
00308233 0000010C 1 04 12345002 0 00000000
402202B3 00000110 1 05 12345007 0 00000000
00312333 00000114 1 06 00000001 0 00000000
003133B3 00000118 1 07 00000000 0 00000000
0FF0C413 0000011C 1 08 123450FF 0 00000000
00419493 00000120 1 09 00000020 0 00000000
40115513 00000124 1 0A FFFFFFFD 0 00000000
01C15593 00000128 1 0B 0000000F 0 00000000
0064E633 0000012C 1 0C 00000021 0 00000000
00A476B3 00000130 1 0D 123450FD 0 00000000
00108013 00000134 0 00 00000000 0 00000000
00001717 00000138 1 0E 00001138 0 00000000
00C007EF 0000013C 1 0F 00000140 1 00000148
00100813 00000140 1 10 00000001 0 00000000
00200813 00000144 1 10 00000002 0 00000000
00300813 00000148 1 10 00000003 0 00000000
134608E7 0000014C 1 11 00000150 1 00000154
00700913 00000150 1 12 00000007 0 00000000
00730463 00000154 0 00 00000000 0 00000000
00731463 00000158 0 00 00000000 1 00000160
00900993 0000015C 1 13 00000009 0 00000000
00314463 00000160 0 00 00000000 1 00000168
00A00993 00000164 1 13 0000000A 0 00000000
00315463 00000168 0 00 00000000 0 00000000
00316463 0000016C 0 00 00000000 0 00000000
00317463 00000170 0 00 00000000 1 00000178
00B00993 00000174 1 13 0000000B 0 00000000
01180A33 00000178 1 14 00000153 0 00000000
001A0A93 0000017C 1 15 00000154 0 00000000

// File: compile.f
hdl/rv_exec_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_operand_stage.sv
hdl/rv_alu_stage.sv
hdl/rv_exec_top.sv
verification/tb_rv_exec.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - files:
      - hdl/rv_exec_pkg.sv
      - hdl/rv_decoder.sv
      - hdl/rv_regfile.sv
      - hdl/rv_operand_stage.sv
      - hdl/rv_alu_stage.sv
      - hdl/rv_exec_top.sv

  - target: simulation
    files:
      - verification/tb_rv_exec.sv

export_include_dirs: []

dependencies: {}

// File: verification/tb_rv_exec.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_exec;

    import rv_exec_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int COLS      = 7;   // inst, pc, wb, rd, data, redirect, target.

    logic        clk = 1'b0;
    logic        rst_n;
    logic        stall;
    logic        inst_valid;
    inst_u       inst;
    logic [31:0] pc;
    wb_t         wb;
    logic        redirect;
    logic [31:0] redirect_pc;

    logic [31:0] case_mem [0:MAX_CASES*COLS-1];
    int          n_cases;
    int          pending [MAX_CASES];
    bit          case_err [MAX_CASES];
    int          wb_q [$];
    int          redir_q [$];
    int          pass_cnt;
    int          fail_cnt;
    int          other_errs;
    int          cycle_cnt = 0;
    int          timeout_limit = 1000;
    logic [31:0] lfsr;

    rv_exec_top #(.PC_BITS(32)) dut0
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_stall        (stall),
        .i_inst_valid   (inst_valid),
        .i_inst         (inst),
        .i_pc           (pc),
        .o_wb           (wb),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit)
        begin
            $display("Timeout, run did not finish within %0d cycles", timeout_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] field(input int c, input int col);
        return case_mem[c*COLS + col];
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic int find_case(input logic [31:0] target);
        for (int c = 0; c < n_cases; c++)
            if (field(c, 1) == target)
                return c;
        return -1;
    endfunction

    task automatic close_case(input int c);
        if (case_err[c])
        begin
            fail_cnt++;
            $display("case %0d pc %08h finished with mismatches", c, field(c, 1));
        end
        else
        begin
            pass_cnt++;
            $display("case %0d pc %08h ok", c, field(c, 1));
        end
    endtask

    task automatic accept_case(input int c);
        pending[c]  = 0;
        case_err[c] = 1'b0;
        if (field(c, 2) != 0)
        begin
            wb_q.push_back(c);
            pending[c]++;
        end
        if (field(c, 5) != 0)
        begin
            redir_q.push_back(c);
            pending[c]++;
        end
        if (pending[c] == 0)
            close_case(c);      // Nothing observable, e.g. x0 or branch not taken.
    endtask

    task automatic check_writeback();
        int          c;
        logic [31:0] exp_rd;
        logic [31:0] exp_data;
        if (wb.valid === 1'b1)
        begin
            if (wb_q.size() == 0)
            begin
                other_errs++;
                $display("Unexpected writeback to x%0d at %0t", wb.rd, $time);
            end
            else
            begin
                c        = wb_q.pop_front();
                exp_rd   = field(c, 3);
                exp_data = field(c, 4);
                if (wb.rd !== exp_rd[4:0])
                begin
                    $display("[FAIL] %0t o_wb.rd case %0d: expected %0d, got %0d",
                             $time, c, exp_rd[4:0], wb.rd);
                    case_err[c] = 1'b1;
                end
                if (wb.data !== exp_data)
                begin
                    $display("[FAIL] %0t o_wb.data case %0d: expected %08h, got %08h",
                             $time, c, exp_data, wb.data);
                    case_err[c] = 1'b1;
                end
                pending[c]--;
                if (pending[c] == 0)
                    close_case(c);
            end
        end
    endtask

    task automatic check_redirect();
        int          c;
        logic [31:0] exp_tgt;
        if (redir_q.size() == 0)
        begin
            other_errs++;
            $display("Unexpected redirect to %08h at %0t", redirect_pc, $time);
        end
        else
        begin
            c       = redir_q.pop_front();
            exp_tgt = field(c, 6);
            if (redirect_pc !== exp_tgt)
            begin
                $display("[FAIL] %0t o_redirect_pc case %0d: expected %08h, got %08h",
                         $time, c, exp_tgt, redirect_pc);
                case_err[c] = 1'b1;
            end
            pending[c]--;
            if (pending[c] == 0)
                close_case(c);
        end
    endtask

    initial
    begin
        int   idx;
        int   drain;
        int   tgt_idx;
        logic b0;
        logic b1;
        rst_n      = 1'b0;
        stall      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        lfsr       = 32'h8e77;
        pass_cnt   = 0;
        fail_cnt   = 0;
        other_errs = 0;
        n_cases    = 0;
        $readmemh("verification/rv_exec_cases.txt", case_mem);
        while (n_cases < MAX_CASES && !$isunknown(case_mem[n_cases*COLS]))
            n_cases++;
        timeout_limit = 8 * n_cases + 50;
        if (n_cases == 0)
        begin
            other_errs++;
            $display("No cases could be read from the cases file");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idx   = 0;
        drain = 0;
        while (drain < 4)
        begin
            @(negedge clk);
            if (idx < n_cases)
            begin
                take_bit(b0);
                take_bit(b1);
                stall      = b0 & b1;   // One cycle in four.
                inst_valid = 1'b1;
                inst       = field(idx, 0);
                pc         = field(idx, 1);
                drain      = 0;
            end
            else
            begin
                stall      = 1'b0;
                inst_valid = 1'b0;
                drain++;
            end
            #5;
            check_writeback();
            if (redirect === 1'b1)
            begin
                // Presented instruction is flushed.
                check_redirect();
                tgt_idx = find_case(redirect_pc);
                if (tgt_idx < 0)
                begin
                    other_errs++;
                    $display("Redirect target %08h has no line in the cases file", redirect_pc);
                    idx = n_cases;
                end
                else
                    idx = tgt_idx;
            end
            else if (inst_valid && !stall)
            begin
                accept_case(idx);
                idx++;
            end
        end

        if (wb_q.size() != 0)
        begin
            other_errs += wb_q.size();
            $display("%0d expected writebacks never appeared", wb_q.size());
        end
        if (redir_q.size() != 0)
        begin
            other_errs += redir_q.size();
            $display("%0d expected redirects never appeared", redir_q.size());
        end
        $display("cases passed %0d, failed %0d, other errors %0d",
                 pass_cnt, fail_cnt, other_errs);
        if (fail_cnt == 0 && other_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/rv_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_top
#(
    parameter int PC_BITS = 32
)
(
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_stall,
    input  wire                         i_inst_valid,
    input  wire rv_exec_pkg::inst_u     i_inst,
    input  wire [31:0]                  i_pc,
    output rv_exec_pkg::wb_t            o_wb,
    output logic                        o_redirect,
    output logic [PC_BITS-1:0]          o_redirect_pc
);

    import rv_exec_pkg::*;

    dec_bundle_t dec;
    ex_bundle_t  ex;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        rd_en;

    assign rd_en = !i_stall;    // Read address holds with the operand stage.

    rv_decoder u_decoder
    (
        .i_inst     (i_inst),
        .i_pc       (i_pc),
        .i_valid    (i_inst_valid),
        .o_dec      (dec),
        .o_rs1      (rs1_idx),
        .o_rs2      (rs2_idx)
    );

    rv_regfile u_regfile
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (rs1_idx),
        .i_rs2      (rs2_idx),
        .i_rd_en    (rd_en),
        .i_wb       (o_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_operand_stage #(.PC_BITS(PC_BITS)) u_operand_stage
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_flush    (o_redirect),
        .i_dec      (dec),
        .i_valid    (i_inst_valid),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_ex       (ex)
    );

    rv_alu_stage #(.PC_BITS(PC_BITS)) u_alu_stage
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (i_stall),
        .i_ex           (ex),
        .o_wb           (o_wb),
        .o_redirect     (o_redirect),
        .o_redirect_pc  (o_redirect_pc)
    );

endmodule

`default_nettype wire

// File: hdl/rv_alu_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu_stage
#(
    parameter int PC_BITS = 32
)
(
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_stall,
    input  wire rv_exec_pkg::ex_bundle_t    i_ex,
    output rv_exec_pkg::wb_t                o_wb,
    output logic                            o_redirect,
    output logic [PC_BITS-1:0]              o_redirect_pc
);

    import rv_exec_pkg::*;

    logic [31:0] alu_res;
    logic [4:0]  shamt;
    logic        taken;
    logic        fire;
    logic [31:0] link_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    assign shamt = i_ex.op2[4:0];

    always_comb
    begin
        case (i_ex.ctrl.alu_op)
            ALU_SUB:    alu_res = i_ex.op1 - i_ex.op2;
            ALU_SLL:    alu_res = i_ex.op1 << shamt;
            ALU_SLT:    alu_res = 32'($signed(i_ex.op1) < $signed(i_ex.op2));
            ALU_SLTU:   alu_res = 32'(i_ex.op1 < i_ex.op2);
            ALU_XOR:    alu_res = i_ex.op1 ^ i_ex.op2;
            ALU_SRL:    alu_res = i_ex.op1 >> shamt;
            ALU_SRA:    alu_res = $signed(i_ex.op1) >>> shamt;
            ALU_OR:     alu_res = i_ex.op1 | i_ex.op2;
            ALU_AND:    alu_res = i_ex.op1 & i_ex.op2;
            ALU_PASS_B: alu_res = i_ex.op2;
            default:    alu_res = i_ex.op1 + i_ex.op2;
        endcase
    end

    // Compare on register data, not on the muxed operands.
    always_comb
    begin
        case (i_ex.ctrl.funct3)
            3'b000:  taken = (i_ex.rs1_data == i_ex.rs2_data);
            3'b001:  taken = (i_ex.rs1_data != i_ex.rs2_data);
            3'b100:  taken = ($signed(i_ex.rs1_data) < $signed(i_ex.rs2_data));
            3'b101:  taken = ($signed(i_ex.rs1_data) >= $signed(i_ex.rs2_data));
            3'b110:  taken = (i_ex.rs1_data < i_ex.rs2_data);
            3'b111:  taken = (i_ex.rs1_data >= i_ex.rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign fire          = i_ex.valid && !i_stall;
    assign o_redirect    = fire && (i_ex.ctrl.jal || i_ex.ctrl.jalr ||
                                    (i_ex.ctrl.branch && taken));
    assign o_redirect_pc = i_ex.pc_target[PC_BITS-1:0];
    assign link_addr     = 32'(i_ex.link[PC_BITS-1:0]);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= fire && i_ex.ctrl.reg_write && (i_ex.rd != 5'd0);
    end

    always_ff @(posedge i_clk)
    begin
        wb_rd   <= i_ex.rd;
        wb_data <= (i_ex.ctrl.jal || i_ex.ctrl.jalr) ? link_addr : alu_res;
    end

    assign o_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

`default_nettype wire

// File: hdl/rv_operand_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rv_operand_stage
#(
    parameter int PC_BITS = 32
)
(
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_stall,
    input  wire                             i_flush,
    input  wire rv_exec_pkg::dec_bundle_t   i_dec,
    input  wire                             i_valid,
    input  wire [31:0]                      i_rs1_data,
    input  wire [31:0]                      i_rs2_data,
    output rv_exec_pkg::ex_bundle_t         o_ex
);

    import rv_exec_pkg::*;

    localparam logic [PC_BITS-1:1] PC_STEP = 2;     // 4 bytes.

    logic               valid_q;
    dec_ctrl_t          ctrl_q;
    logic [4:0]         rd_q;
    logic [31:0]        imm_q;
    logic [PC_BITS-1:1] pc_q;
    logic [31:0]        op1;
    logic [31:0]        op2;
    logic [PC_BITS-1:1] tgt_base;
    logic [PC_BITS-1:1] tgt_offset;
    logic               tgt_carry;
    logic [PC_BITS-1:1] pc_target;
    logic [PC_BITS-1:1] link;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= CTRL_NOP;
            rd_q    <= '0;
        end
        else if (!i_stall)
        begin
            valid_q <= i_valid;
            ctrl_q  <= i_dec.ctrl;
            rd_q    <= i_dec.rd;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            imm_q <= i_dec.imm;
            pc_q  <= i_dec.pc[PC_BITS-1:1];
        end
    end

    assign op1 = ctrl_q.op1_pc ? 32'({pc_q, 1'b0}) : i_rs1_data;
    assign op2 = ctrl_q.op2_imm ? imm_q : i_rs2_data;

    assign tgt_base   = ctrl_q.jalr ? i_rs1_data[PC_BITS-1:1] : pc_q;
    assign tgt_offset = imm_q[PC_BITS-1:1];
    assign tgt_carry  = ctrl_q.jalr && i_rs1_data[0] && imm_q[0]; // Lost bit 0 carry.
    assign pc_target  = tgt_base + tgt_offset + tgt_carry;
    assign link       = pc_q + PC_STEP;

    assign o_ex = '{
        valid:     valid_q,
        ctrl:      ctrl_q,
        rd:        rd_q,
        op1:       op1,
        op2:       op2,
        rs1_data:  i_rs1_data,
        rs2_data:  i_rs2_data,
        pc:        32'({pc_q, 1'b0}),
        link:      32'({link, 1'b0}),
        pc_target: 32'({pc_target, 1'b0})
    };

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire [4:0]               i_rs1,
    input  wire [4:0]               i_rs2,
    input  wire                     i_rd_en,
    input  wire rv_exec_pkg::wb_t   i_wb,
    output logic [31:0]             o_rs1_data,
    output logic [31:0]             o_rs2_data
);

    logic [31:0] regs [1:31];
    logic [4:0]  raddr [2];
    logic [4:0]  raddr_q [2];
    logic [31:0] fresh [2];
    logic [31:0] rdata_q [2];
    logic [31:0] rdata [2];

    assign raddr[0] = i_rs1;
    assign raddr[1] = i_rs2;

    always_ff @(posedge i_clk)
    begin
        if (i_wb.valid && (i_wb.rd != 5'd0))
            regs[i_wb.rd] <= i_wb.data;
    end

    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (raddr[p] == 5'd0)
                fresh[p] = '0;
            else if (i_wb.valid && (i_wb.rd == raddr[p]))
                fresh[p] = i_wb.data;   // Write-through.
            else
                fresh[p] = regs[raddr[p]];
            // Pending writeback to the held address wins.
            if (i_wb.valid && (raddr_q[p] != 5'd0) && (i_wb.rd == raddr_q[p]))
                rdata[p] = i_wb.data;
            else
                rdata[p] = rdata_q[p];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int p = 0; p < 2; p++)
            begin
                raddr_q[p] <= '0;
                rdata_q[p] <= '0;
            end
        end
        else
        begin
            for (int p = 0; p < 2; p++)
            begin
                if (i_rd_en)
                begin
                    raddr_q[p] <= raddr[p];
                    rdata_q[p] <= fresh[p];
                end
                else
                    rdata_q[p] <= rdata[p];     // Held read picks up late writes.
            end
        end
    end

    assign o_rs1_data = rdata[0];
    assign o_rs2_data = rdata[1];

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder
(
    input  wire rv_exec_pkg::inst_u         i_inst,
    input  wire [31:0]                      i_pc,
    input  wire                             i_valid,
    output rv_exec_pkg::dec_bundle_t        o_dec,
    output logic [4:0]                      o_rs1,
    output logic [4:0]                      o_rs2
);

    import rv_exec_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm;
    dec_ctrl_t   ctrl;

    // SUB only exists in the register form.
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt,
                                         input logic sub_ok);
        case (funct3)
            3'b000:  return (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = i_inst.r.opcode;
    assign f3     = i_inst.r.funct3;

    assign imm_i = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
    assign imm_b = {{19{i_inst.b.imm12}}, i_inst.b.imm12, i_inst.b.imm11,
                    i_inst.b.imm10_5, i_inst.b.imm4_1, 1'b0};
    assign imm_u = {i_inst.u.imm31_12, 12'h000};
    assign imm_j = {{11{i_inst.j.imm20}}, i_inst.j.imm20, i_inst.j.imm19_12,
                    i_inst.j.imm11, i_inst.j.imm10_1, 1'b0};

    always_comb
    begin
        ctrl = CTRL_NOP;
        imm  = imm_i;
        case (opcode)
            OPC_OP:
            begin
                ctrl.alu_op    = arith_op(f3, i_inst.r.funct7[5], 1'b1);
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                ctrl.alu_op    = arith_op(f3, i_inst.r.funct7[5], 1'b0); // imm[10] picks SRA.
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_LUI:
            begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            OPC_AUIPC:
            begin
                ctrl.op1_pc    = 1'b1;
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            OPC_JAL:
            begin
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_j;
            end
            OPC_JALR:
            begin
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_BRANCH:
            begin
                ctrl.branch = (f3[2:1] != 2'b01);   // 010 and 011 are reserved.
                ctrl.funct3 = f3;
                imm         = imm_b;
            end
            default: ;
        endcase
        if (!i_valid)
            ctrl = CTRL_NOP;
    end

    assign o_rs1 = i_inst.r.rs1;
    assign o_rs2 = i_inst.r.rs2;

    assign o_dec = '{
        ctrl: ctrl,
        rd:   i_inst.r.rd,
        rs1:  i_inst.r.rs1,
        rs2:  i_inst.r.rs2,
        imm:  imm,
        pc:   i_pc
    };

endmodule

`default_nettype wire

// File: hdl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // LUI.
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    // One instruction word, viewed per format.
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       op1_pc;
        logic       op2_imm;
        logic       reg_write;
        logic       jal;
        logic       jalr;
        logic       branch;
        logic [2:0] funct3;     // Branch condition.
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t   ctrl;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [31:0] pc;
    } dec_bundle_t;

    typedef struct packed {
        logic        valid;
        dec_ctrl_t   ctrl;
        logic [4:0]  rd;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] pc;
        logic [31:0] link;
        logic [31:0] pc_target;
    } ex_bundle_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    localparam dec_ctrl_t CTRL_NOP = '{
        alu_op:    ALU_ADD,
        op1_pc:    1'b0,
        op2_imm:   1'b0,
        reg_write: 1'b0,
        jal:       1'b0,
        jalr:      1'b0,
        branch:    1'b0,
        funct3:    3'b000
    };

endpackage

`default_nettype wire
